//--- design/srcPkg.sv
`default_nettype none

package srcPkg;

    localparam int WORD_W      = 32;                     // bus and instruction width
    localparam int REG_COUNT   = 16;                     // general purpose registers
    localparam int REG_IDX_W   = 4;                      // register field width
    localparam int ADDR_W      = 8;                      // program address width
    localparam int IMM_W       = 15;                     // immediate field width
    localparam int OPCODE_W    = 5;                      // opcode field width
    localparam int MEM_DEPTH   = 256;                    // program store words
    localparam int MEM_LATENCY = 2;                      // read pipeline depth, one per wait state
    localparam int OUT_CREDITS = 2;                      // sink credits after reset
    localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1); // holds 0..OUT_CREDITS

    typedef logic [WORD_W-1:0]    wordT;                 // data word
    typedef logic [REG_IDX_W-1:0] regIdxT;               // R0..R15
    typedef logic [ADDR_W-1:0]    addrT;                 // word address
    typedef logic [IMM_W-1:0]     immT;                  // C field
    typedef logic [CREDIT_W-1:0]  creditT;               // output port credits

    // SRC encodings for the supported subset
    typedef enum logic [OPCODE_W-1:0] {
        opLdi  = 5'b00001,                               // Ra <- imm
        opAdd  = 5'b00011,                               // Ra <- Rb + Rc
        opIn   = 5'b10110,                               // Ra <- in port
        opOut  = 5'b10111,                               // out port <- Ra
        opHalt = 5'b11011                                // stop
    } opcodeT;

    typedef enum logic [3:0] {
        sIdle     = 4'b0000,                             // waiting for start
        sT0       = 4'b0001,                             // fetch, pc to mar
        sT1       = 4'b0010,                             // fetch, pc update, read
        sMemWait1 = 4'b1100,
        sMemWait2 = 4'b1101,
        sT2       = 4'b0011,                             // mdr to ir
        sT3       = 4'b0100,                             // execute
        sT4       = 4'b0101,                             // execute, writeback
        sHalted   = 4'b1111                              // after halt
    } seqStateT;

    typedef struct packed {
        opcodeT opcode;                                  // bits 31:27
        regIdxT ra;                                      // bits 26:23
        regIdxT rb;                                      // bits 22:19
        regIdxT rc;                                      // bits 18:15
        immT    imm;                                     // bits 14:0
    } instrT;

    typedef struct packed {
        logic pcOut;                                     // pc onto bus
        logic marIn;                                     // bus into mar
        logic incPc;                                     // z takes pc+1
        logic zIn;                                       // load z
        logic zOut;                                      // z onto bus
        logic pcEn;                                      // bus into pc
        logic memRead;                                   // start program read
        logic mdrIn;                                     // memory data into mdr
        logic mdrOut;                                    // mdr onto bus
        logic irIn;                                      // bus into ir
        logic gra;                                       // select Ra field
        logic grb;                                       // select Rb field
        logic grc;                                       // select Rc field
        logic rIn;                                       // bus into selected reg
        logic rOut;                                      // selected reg onto bus
        logic cOut;                                      // immediate onto bus
        logic inPortOut;                                 // input register onto bus
        logic outPortEn;                                 // bus into output port
    } ctrlT;

endpackage

`default_nettype wire

//--- design/controlSequencer.sv
`default_nettype none

module controlSequencer (
    input  wire            clock,
    input  wire            rstN,
    input  wire            start,                        // leave idle or halted
    input  wire  srcPkg::instrT instr,                   // current ir
    input  wire            outReady,                     // output credit available
    output srcPkg::ctrlT   ctrl,
    output logic           halted
);
    import srcPkg::*;

    seqStateT state;
    seqStateT nextState;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= sIdle;
        end else begin
            state <= nextState;
        end
    end

    // fixed fetch sequence, opcode only matters in T3
    always_comb begin
        nextState = state;
        case (state)
            sIdle, sHalted: begin
                if (start) begin
                    nextState = sT0;                     // pc cleared in datapath
                end
            end
            sT0:       nextState = sT1;
            sT1:       nextState = sMemWait1;
            sMemWait1: nextState = sMemWait2;
            sMemWait2: nextState = sT2;                  // read data lands in mdr here
            sT2:       nextState = sT3;
            sT3: begin
                if (instr.opcode == opHalt) begin
                    nextState = sHalted;
                end else if (instr.opcode == opOut && !outReady) begin
                    nextState = sT3;                     // back-pressure, hold
                end else begin
                    nextState = sT4;
                end
            end
            sT4:       nextState = sT0;                  // next instruction
            default:   nextState = sIdle;
        endcase
    end

    // strobes decoded straight from state and ir
    always_comb begin
        ctrl = '0;
        case (state)
            sT0: begin
                ctrl.pcOut = 1'b1;                       // mar <- pc
                ctrl.marIn = 1'b1;
                ctrl.incPc = 1'b1;                       // z <- pc + 1
                ctrl.zIn   = 1'b1;
            end
            sT1: begin
                ctrl.zOut    = 1'b1;                     // pc <- z
                ctrl.pcEn    = 1'b1;
                ctrl.memRead = 1'b1;                     // one read per fetch
                ctrl.mdrIn   = 1'b1;
            end
            sMemWait1, sMemWait2: begin
                ctrl.mdrIn = 1'b1;                       // keep mdr following memory
            end
            sT2: begin
                ctrl.mdrOut = 1'b1;                      // ir <- mdr
                ctrl.irIn   = 1'b1;
            end
            sT3: begin
                case (instr.opcode)
                    opLdi: begin
                        ctrl.cOut = 1'b1;                // zero-extended C
                        ctrl.gra  = 1'b1;
                        ctrl.rIn  = 1'b1;
                    end
                    opAdd: begin
                        ctrl.grb = 1'b1;                 // adder reads Rb and Rc
                        ctrl.grc = 1'b1;
                        ctrl.zIn = 1'b1;
                    end
                    opIn: begin
                        ctrl.inPortOut = 1'b1;
                        ctrl.gra       = 1'b1;
                        ctrl.rIn       = 1'b1;
                    end
                    opOut: begin
                        ctrl.gra       = 1'b1;
                        ctrl.rOut      = 1'b1;
                        ctrl.outPortEn = outReady;       // only fire with a credit
                    end
                    default: ;                           // halt and unknown do nothing
                endcase
            end
            sT4: begin
                if (instr.opcode == opAdd) begin
                    ctrl.zOut = 1'b1;                    // Ra <- z
                    ctrl.gra  = 1'b1;
                    ctrl.rIn  = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign halted = (state == sHalted);

endmodule

`default_nettype wire

//--- design/busDatapath.sv
`default_nettype none

module busDatapath (
    input  wire           clock,
    input  wire           rstN,
    input  wire  srcPkg::ctrlT ctrl,
    input  wire  srcPkg::wordT memData,                  // program memory read data
    input  wire  srcPkg::wordT inPortData,               // input port register
    input  wire           start,                         // clears pc
    output srcPkg::addrT  memAddr,
    output srcPkg::instrT instr,
    output srcPkg::wordT  busOut
);
    import srcPkg::*;

    wordT   regFile [REG_COUNT];                         // R0..R15
    addrT   pc;
    addrT   mar;
    wordT   mdr;
    wordT   z;                                           // incrementer/adder result
    instrT  ir;
    regIdxT regSel;                                      // field picked by gra/grb/grc
    wordT   regData;
    wordT   immExt;
    wordT   busMux;
    wordT   addA;                                        // Rb when grb
    wordT   addB;                                        // Rc when grc

    // Ra wins over Rb over Rc
    always_comb begin
        if (ctrl.gra) begin
            regSel = ir.ra;
        end else if (ctrl.grb) begin
            regSel = ir.rb;
        end else if (ctrl.grc) begin
            regSel = ir.rc;
        end else begin
            regSel = '0;
        end
    end

    assign regData = regFile[regSel];
    assign immExt  = wordT'(ir.imm);                     // zero-extend C
    assign addA    = ctrl.grb ? regFile[ir.rb] : '0;     // adder port A
    assign addB    = ctrl.grc ? regFile[ir.rc] : '0;     // adder port B

    // one source at a time on the shared bus
    always_comb begin
        if (ctrl.pcOut) begin
            busMux = wordT'(pc);
        end else if (ctrl.zOut) begin
            busMux = z;
        end else if (ctrl.mdrOut) begin
            busMux = mdr;
        end else if (ctrl.rOut) begin
            busMux = regData;
        end else if (ctrl.inPortOut) begin
            busMux = inPortData;
        end else if (ctrl.cOut) begin
            busMux = immExt;
        end else begin
            busMux = '0;                                 // idle bus
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
            ir <= '0;
        end else begin
            if (start) begin
                pc <= '0;                                // programs begin at 0
            end else if (ctrl.pcEn) begin
                pc <= busMux[ADDR_W-1:0];
            end
            if (ctrl.irIn) begin
                ir <= instrT'(busMux);
            end
        end
    end

    always_ff @(posedge clock) begin
        if (ctrl.marIn) begin
            mar <= busMux[ADDR_W-1:0];
        end
        if (ctrl.mdrIn) begin
            mdr <= memData;                              // last load before T2 wins
        end
        if (ctrl.zIn) begin
            if (ctrl.incPc) begin
                z <= wordT'(addrT'(pc + 1'b1));          // wraps at program size
            end else begin
                z <= addA + addB;                        // mod 2^32
            end
        end
        if (ctrl.rIn) begin
            regFile[regSel] <= busMux;
        end
    end

    assign memAddr = mar;
    assign instr   = ir;
    assign busOut  = busMux;

endmodule

`default_nettype wire

//--- design/programMemory.sv
`default_nettype none

module programMemory (
    input  wire          clock,
    input  wire          progWrite,                      // external load, cpu stopped
    input  wire  srcPkg::addrT progAddr,
    input  wire  srcPkg::wordT progData,
    input  wire          memRead,
    input  wire  srcPkg::addrT memAddr,
    output srcPkg::wordT memData
);
    import srcPkg::*;

    wordT memArray [MEM_DEPTH];
    wordT rdPipe [MEM_LATENCY];                          // read data stages
    logic [MEM_LATENCY-2:0] rdValid;                     // stage i holds a live read

    always_ff @(posedge clock) begin
        if (progWrite) begin
            memArray[progAddr] <= progData;
        end
    end

    // each stage only advances on a live read, so memData holds afterwards
    always_ff @(posedge clock) begin
        rdValid[0] <= memRead;
        for (int i = 1; i < MEM_LATENCY - 1; i++) begin
            rdValid[i] <= rdValid[i-1];
        end
        if (memRead) begin
            rdPipe[0] <= memArray[memAddr];
        end
        for (int i = 1; i < MEM_LATENCY; i++) begin
            if (rdValid[i-1]) begin
                rdPipe[i] <= rdPipe[i-1];
            end
        end
    end

    assign memData = rdPipe[MEM_LATENCY-1];              // valid 2 cycles after memRead

endmodule

`default_nettype wire

//--- design/ioPorts.sv
`default_nettype none

module ioPorts (
    input  wire          clock,
    input  wire          rstN,
    input  wire  srcPkg::wordT inData,
    input  wire          inStrobe,                       // sample inData
    input  wire  srcPkg::wordT busOut,
    input  wire          outPortEn,                      // from sequencer in T3
    input  wire          outCredit,                      // one credit back from sink
    output srcPkg::wordT inPortData,
    output srcPkg::wordT outData,
    output logic         outValid,
    output logic         outReady
);
    import srcPkg::*;

    wordT   inReg;
    wordT   outReg;
    creditT creditCount;                                 // credits held

    always_ff @(posedge clock) begin
        if (inStrobe) begin
            inReg <= inData;
        end
        if (outPortEn) begin
            outReg <= busOut;                            // Ra captured off the bus
        end
    end

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            outValid    <= 1'b0;
            creditCount <= creditT'(OUT_CREDITS);
        end else begin
            outValid <= outPortEn && outReady;           // one-cycle pulse
            case ({outValid, outCredit})
                2'b10: creditCount <= creditCount - 1'b1; // spent on the word
                2'b01: begin
                    if (creditCount < creditT'(OUT_CREDITS)) begin
                        creditCount <= creditCount + 1'b1;
                    end
                end
                default: ;                               // both or neither, no change
            endcase
        end
    end

    assign outReady   = (creditCount != '0);
    assign inPortData = inReg;
    assign outData    = outReg;

endmodule

`default_nettype wire

//--- design/miniSrcIo.sv
`default_nettype none

module miniSrcIo (
    input  wire          clock,
    input  wire          rstN,
    input  wire          progWrite,                      // program load strobe
    input  wire  srcPkg::addrT progAddr,
    input  wire  srcPkg::wordT progData,
    input  wire          start,                          // run from address 0
    input  wire  srcPkg::wordT inData,
    input  wire          inStrobe,
    input  wire          outCredit,                      // credit return from sink
    output srcPkg::wordT outData,
    output logic         outValid,
    output logic         halted
);
    import srcPkg::*;

    ctrlT  ctrl;                                         // sequencer strobes
    instrT instr;                                        // ir back to sequencer
    wordT  busOut;
    wordT  memData;
    addrT  memAddr;
    wordT  inPortData;
    logic  outReady;

    controlSequencer u_controlSequencer (
        .clock    (clock),
        .rstN     (rstN),
        .start    (start),
        .instr    (instr),
        .outReady (outReady),
        .ctrl     (ctrl),
        .halted   (halted)
    );

    busDatapath u_busDatapath (
        .clock      (clock),
        .rstN       (rstN),
        .ctrl       (ctrl),
        .memData    (memData),
        .inPortData (inPortData),
        .start      (start),
        .memAddr    (memAddr),
        .instr      (instr),
        .busOut     (busOut)
    );

    programMemory u_programMemory (
        .clock     (clock),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .memRead   (ctrl.memRead),                       // fetch only
        .memAddr   (memAddr),
        .memData   (memData)
    );

    ioPorts u_ioPorts (
        .clock      (clock),
        .rstN       (rstN),
        .inData     (inData),
        .inStrobe   (inStrobe),
        .busOut     (busOut),
        .outPortEn  (ctrl.outPortEn),
        .outCredit  (outCredit),
        .inPortData (inPortData),
        .outData    (outData),
        .outValid   (outValid),
        .outReady   (outReady)
    );

endmodule

`default_nettype wire

//--- verification/miniSrcIoAssertions.sv
`default_nettype none

module miniSrcIoAssertions (
    input wire                 clock,
    input wire                 rstN,
    input wire                 memRead,                  // tied low where unused
    input wire                 irIn,
    input wire                 outValid,
    input wire srcPkg::creditT creditCount
);
    import srcPkg::*;

    // fetch data reaches ir after both wait states
    irAfterRead: assert property (@(posedge clock) disable iff (!rstN)
        memRead |-> ##3 irIn)
        else $error("irIn did not follow memRead by 3 cycles");

    validNeedsCredit: assert property (@(posedge clock) disable iff (!rstN)
        outValid |-> (creditCount != '0))
        else $error("outValid with no credit held");

    creditBound: assert property (@(posedge clock) disable iff (!rstN)
        creditCount <= creditT'(OUT_CREDITS))
        else $error("credit count above OUT_CREDITS");

    validSinglePulse: assert property (@(posedge clock) disable iff (!rstN)
        outValid |=> !outValid)                          // one word per out instruction
        else $error("outValid held longer than one cycle");

endmodule

bind controlSequencer miniSrcIoAssertions u_seqAssertions (
    .clock(clock), .rstN(rstN), .memRead(ctrl.memRead), .irIn(ctrl.irIn),
    .outValid(1'b0), .creditCount('0));

bind ioPorts miniSrcIoAssertions u_portAssertions (
    .clock(clock), .rstN(rstN), .memRead(1'b0), .irIn(1'b0),
    .outValid(outValid), .creditCount(creditCount));

`default_nettype wire

//--- verification/miniSrcIoTb.sv
`default_nettype none

module miniSrcIoTb;
    import srcPkg::*;

    localparam int NUM_TESTS  = 6;
    localparam int PROG_WORDS = 8;

    typedef struct packed {
        wordT       inValue;                             // sampled before start
        logic [7:0] delayMin;                            // sink credit delay range
        logic [7:0] delayMax;
    } rowT;

    logic clock = 1'b0;
    logic rstN;
    logic progWrite;
    addrT progAddr;
    wordT progData;
    logic start;
    wordT inData;
    logic inStrobe;
    logic outCredit = 1'b0;                              // sink drives this
    wordT outData;
    logic outValid;
    logic halted;

    string       testName [NUM_TESTS];
    wordT        progTable [NUM_TESTS][PROG_WORDS];
    rowT         rowTable [NUM_TESTS];
    wordT        expWords [$];
    wordT        gotWords [$];
    int          creditDue [$];                          // cycle each credit goes back
    int          currentRow = 0;
    int          unanswered = 0;                         // words not yet credited
    int          validWhileHalted = 0;
    int          cycleCount = 0;
    int          cycleLimit = 0;
    int unsigned lcgState = 32'd13859;

    miniSrcIo u_dut (
        .clock     (clock),
        .rstN      (rstN),
        .progWrite (progWrite),
        .progAddr  (progAddr),
        .progData  (progData),
        .start     (start),
        .inData    (inData),
        .inStrobe  (inStrobe),
        .outCredit (outCredit),
        .outData   (outData),
        .outValid  (outValid),
        .halted    (halted)
    );

    always #10 clock = ~clock;

    function automatic wordT encodeInstr(opcodeT op, int ra, int rb, int rc, int imm);
        return {op, regIdxT'(ra), regIdxT'(rb), regIdxT'(rc), immT'(imm)};
    endfunction

    function automatic int nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return int'(lcgState >> 16);                     // upper bits cycle less
    endfunction

    function automatic int drawDelay();
        int span;
        span = int'(rowTable[currentRow].delayMax) - int'(rowTable[currentRow].delayMin) + 1;
        return int'(rowTable[currentRow].delayMin) + nextRandom() % span;
    endfunction

    task automatic stopOnFailure(string reason);
        $display("Some tests failed");
        $fatal(1, "%s", reason);
    endtask

    task automatic compareValues(string what, wordT expected, wordT actual);
        if (expected !== actual) begin
            $display("ERROR %s: expected %h, actual %h", what, expected, actual);
            stopOnFailure("value mismatch");
        end
    endtask

    task automatic stepCycle();
        @(posedge clock);
        #2;                                              // inputs move after the edge
    endtask

    task automatic fillTable();
        foreach (progTable[t, i]) begin
            progTable[t][i] = encodeInstr(opHalt, 0, 0, 0, 0); // unused slots halt
        end
        testName[0] = "ldiOut";
        rowTable[0] = '{32'h0, 8'd1, 8'd3};
        progTable[0][0] = encodeInstr(opLdi, 1, 0, 0, 'h7abc);
        progTable[0][1] = encodeInstr(opOut, 1, 0, 0, 0);
        testName[1] = "inOut";
        rowTable[1] = '{32'hdeadbeef, 8'd2, 8'd6};
        progTable[1][0] = encodeInstr(opIn, 2, 0, 0, 0);
        progTable[1][1] = encodeInstr(opOut, 2, 0, 0, 0);
        testName[2] = "addOut";
        rowTable[2] = '{32'h0, 8'd1, 8'd5};
        progTable[2][0] = encodeInstr(opLdi, 1, 0, 0, 'h1234);
        progTable[2][1] = encodeInstr(opLdi, 2, 0, 0, 'h7fff);
        progTable[2][2] = encodeInstr(opAdd, 3, 1, 2, 0);
        progTable[2][3] = encodeInstr(opOut, 3, 0, 0, 0);
        testName[3] = "addWrap";                         // 0xfffffff0 + 0x25 wraps
        rowTable[3] = '{32'hfffffff0, 8'd1, 8'd5};
        progTable[3][0] = encodeInstr(opIn, 1, 0, 0, 0);
        progTable[3][1] = encodeInstr(opLdi, 2, 0, 0, 'h25);
        progTable[3][2] = encodeInstr(opAdd, 3, 1, 2, 0);
        progTable[3][3] = encodeInstr(opOut, 3, 0, 0, 0);
        testName[4] = "burstOut";                        // slow sink causes back-pressure
        rowTable[4] = '{32'h0, 8'd30, 8'd40};
        progTable[4][0] = encodeInstr(opLdi, 1, 0, 0, 'h11);
        progTable[4][1] = encodeInstr(opLdi, 2, 0, 0, 'h22);
        for (int i = 2; i < 7; i++) begin
            progTable[4][i] = encodeInstr(opOut, (i % 2) + 1, 0, 0, 0);
        end
        testName[5] = "haltRestart";                     // words after halt never run
        rowTable[5] = '{32'h0, 8'd1, 8'd3};
        progTable[5][0] = encodeInstr(opLdi, 4, 0, 0, 'h5a5);
        progTable[5][1] = encodeInstr(opOut, 4, 0, 0, 0);
        progTable[5][3] = encodeInstr(opLdi, 5, 0, 0, 'h1);
        progTable[5][4] = encodeInstr(opOut, 5, 0, 0, 0);
    endtask

    // instruction-level model of the subset
    task automatic computeExpected(int t);
        wordT regs [REG_COUNT];
        wordT w;
        int   pc;
        bit   running;
        expWords.delete();
        foreach (regs[r]) regs[r] = '0;
        pc = 0;
        running = 1'b1;
        while (running && pc < PROG_WORDS) begin
            w  = progTable[t][pc];
            pc = pc + 1;
            case (w[31:27])
                opLdi:   regs[w[26:23]] = {17'd0, w[14:0]};
                opAdd:   regs[w[26:23]] = regs[w[22:19]] + regs[w[18:15]];
                opIn:    regs[w[26:23]] = rowTable[t].inValue;
                opOut:   expWords.push_back(regs[w[26:23]]);
                default: running = 1'b0;                 // halt
            endcase
        end
    endtask

    task automatic runTest(int t);
        currentRow = t;
        for (int i = 0; i < PROG_WORDS; i++) begin
            progWrite = 1'b1;
            progAddr  = addrT'(i);
            progData  = progTable[t][i];
            stepCycle();
        end
        progWrite = 1'b0;
        inData    = rowTable[t].inValue;
        inStrobe  = 1'b1;
        stepCycle();
        inStrobe = 1'b0;
        inData   = ~rowTable[t].inValue;                 // port must keep the strobed value
        compareValues({testName[t], " words before start"}, 0, gotWords.size());
        computeExpected(t);
        validWhileHalted = 0;
        start = 1'b1;
        stepCycle();
        start = 1'b0;
        while (!halted) stepCycle();
        while (unanswered != 0) stepCycle();            // drain sink credits
        repeat (4) stepCycle();
        compareValues({testName[t], " word count"}, expWords.size(), gotWords.size());
        foreach (expWords[i]) begin
            compareValues({testName[t], " word"}, expWords[i], gotWords[i]);
        end
        compareValues({testName[t], " outValid while halted"}, 0, validWhileHalted);
        gotWords.delete();
    endtask

    // sink collects words, returns credits late and watches the cycle budget
    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            $display("timeout: run went past %0d cycles", cycleLimit);
            stopOnFailure("simulation timed out");
        end
        if (rstN) begin
            if (outValid) begin
                gotWords.push_back(outData);
                creditDue.push_back(cycleCount + drawDelay());
                if (halted) validWhileHalted++;
            end
            unanswered = unanswered + int'(outValid) - int'(outCredit);
            if (unanswered > OUT_CREDITS) begin
                $display("sink holds %0d unanswered words, more than the credits", unanswered);
                stopOnFailure("credit overrun");
            end
        end
        #2;
        outCredit = 1'b0;
        if (creditDue.size() > 0 && creditDue[0] <= cycleCount) begin
            void'(creditDue.pop_front());
            outCredit = 1'b1;                            // one-cycle pulse
        end
    end

    initial begin
        rstN      = 1'b0;
        progWrite = 1'b0;
        progAddr  = '0;
        progData  = '0;
        start     = 1'b0;
        inData    = '0;
        inStrobe  = 1'b0;
        fillTable();
        for (int t = 0; t < NUM_TESTS; t++) begin
            cycleLimit += PROG_WORDS * 7 + PROG_WORDS * int'(rowTable[t].delayMax);
        end
        cycleLimit = cycleLimit * 2;
        repeat (5) @(posedge clock);
        #2;
        rstN = 1'b1;
        repeat (10) begin                                // idle with no start yet
            stepCycle();
            compareValues("resetIdle outValid", 0, outValid);
            compareValues("resetIdle halted", 0, halted);
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            runTest(t);
        end
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/srcPkg.sv
design/controlSequencer.sv
design/busDatapath.sv
design/programMemory.sv
design/ioPorts.sv
design/miniSrcIo.sv
verification/miniSrcIoAssertions.sv
verification/miniSrcIoTb.sv

//--- Makefile
SRCS := $(shell cat files.f)

obj_dir/VminiSrcIoTb: files.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f files.f --top-module miniSrcIoTb -o VminiSrcIoTb

run: obj_dir/VminiSrcIoTb
	./obj_dir/VminiSrcIoTb

clean:
	rm -rf obj_dir

.PHONY: run clean
